// File: Bender.yml
package:
  name: dma_subsystem

sources:
  - hdl/dma_pkg.sv
  - hdl/dma_registers.sv
  - hdl/dma_burst_engine.sv
  - hdl/dma_local_sram.sv
  - hdl/dma_subsystem.sv
  - target: test
    files:
      - verification/dma_bus_target.sv
      - verification/dma_tb.sv

// File: filelist.f
hdl/dma_pkg.sv
hdl/dma_registers.sv
hdl/dma_burst_engine.sv
hdl/dma_local_sram.sv
hdl/dma_subsystem.sv
verification/dma_bus_target.sv
verification/dma_tb.sv

// File: hdl/dma_burst_engine.sv
// DMA bus master burst engine
module dma_burst_engine #(
    parameter int MEMORY_ADDRESS_WIDTH = 9
) (
    input  logic                            clock,
    input  logic                            reset,
    input  dma_pkg::dma_config_t            config_in,
    input  logic                            start,
    output logic                            done,
    output logic                            abort,
    output logic                            request,
    input  dma_pkg::bus_target_t            bus_in,
    output dma_pkg::bus_master_t            bus_out,
    output logic [MEMORY_ADDRESS_WIDTH-1:0] sram_address,
    output logic                            sram_write_enable,
    output logic [31:0]                     sram_write_data,
    input  logic [31:0]                     sram_read_data
);

    dma_pkg::dma_transfer_state_e          state;
    dma_pkg::dma_transfer_state_e          state_next;
    logic [31:0]                           bus_address;
    logic [MEMORY_ADDRESS_WIDTH-1:0]       sram_index;
    logic [MEMORY_ADDRESS_WIDTH-1:0]       fetch_offset;
    logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0]  remaining_words;
    logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0]  words_left_minus_one;
    logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0]  burst_counter;
    logic [dma_pkg::BURST_SIZE_WIDTH-1:0]  word_counter;
    logic [dma_pkg::BURST_SIZE_WIDTH-1:0]  effective_burst_size;
    logic [31:0]                           write_word;
    logic                                  to_memory;
    logic                                  read_accept;
    logic                                  write_take;
    logic                                  last_burst;

    assign to_memory = config_in.direction == dma_pkg::direction_bus_to_memory;
    assign read_accept = state == dma_pkg::state_read_burst && bus_in.data_valid;
    // Target takes the held word on every cycle without busy
    assign write_take = state == dma_pkg::state_write_burst && !bus_in.busy;
    assign last_burst = burst_counter + 1'b1 == config_in.transfer_count;
    assign words_left_minus_one = remaining_words - 1'b1;

    always_comb begin
        state_next = state;
        case (state)
            dma_pkg::state_idle: begin
                if (start) begin
                    state_next = dma_pkg::state_request_bus;
                end
            end
            dma_pkg::state_request_bus: begin
                if (bus_in.grant) begin
                    state_next = dma_pkg::state_init_burst;
                end
            end
            dma_pkg::state_init_burst: begin
                state_next = to_memory ? dma_pkg::state_read_burst : dma_pkg::state_write_burst;
            end
            dma_pkg::state_read_burst: begin
                if (bus_in.end_transaction) begin
                    state_next = dma_pkg::state_end_burst;
                end
            end
            dma_pkg::state_write_burst: begin
                if (write_take && word_counter == effective_burst_size) begin
                    state_next = dma_pkg::state_end_burst;
                end
            end
            dma_pkg::state_end_burst: begin
                state_next = last_burst ? dma_pkg::state_idle : dma_pkg::state_request_bus;
            end
            default: state_next = dma_pkg::state_idle;
        endcase
        // Target error overrides everything while a transfer is active
        if (bus_in.error && state != dma_pkg::state_idle &&
            state != dma_pkg::state_bus_error) begin
            state_next = dma_pkg::state_bus_error;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dma_pkg::state_idle;
        end else begin
            state <= state_next;
        end
    end

    // Transfer pointers and counters, loaded at start
    always_ff @(posedge clock) begin
        case (state)
            dma_pkg::state_idle: begin
                if (start) begin
                    bus_address <= config_in.bus_start_address;
                    sram_index <= config_in.memory_start_address[MEMORY_ADDRESS_WIDTH-1:0];
                    remaining_words <= config_in.block_size;
                    burst_counter <= '0;
                end
            end
            dma_pkg::state_request_bus: begin
                // Last burst is cut to the words left
                if (words_left_minus_one < config_in.burst_size) begin
                    effective_burst_size <=
                        words_left_minus_one[dma_pkg::BURST_SIZE_WIDTH-1:0];
                end else begin
                    effective_burst_size <= config_in.burst_size;
                end
            end
            dma_pkg::state_init_burst: begin
                word_counter <= '0;
                write_word <= sram_read_data;
            end
            dma_pkg::state_end_burst: burst_counter <= burst_counter + 1'b1;
            default: ;
        endcase
        if (read_accept || write_take) begin
            bus_address <= bus_address + 32'd4;
            sram_index <= sram_index + 1'b1;
            remaining_words <= remaining_words - 1'b1;
            word_counter <= word_counter + 1'b1;
        end
        // Prefetched word replaces the one just taken
        if (write_take) begin
            write_word <= sram_read_data;
        end
    end

    // Keep the SRAM read one word ahead of the bus
    always_comb begin
        fetch_offset = '0;
        if (!to_memory && (state == dma_pkg::state_init_burst ||
                           state == dma_pkg::state_write_burst)) begin
            fetch_offset = write_take ? MEMORY_ADDRESS_WIDTH'(2) : MEMORY_ADDRESS_WIDTH'(1);
        end
    end

    assign sram_address = sram_index + fetch_offset;
    assign sram_write_enable = read_accept;
    assign sram_write_data = bus_in.address_data;

    always_comb begin
        bus_out = '0;
        if (state == dma_pkg::state_init_burst) begin
            bus_out.address_data = bus_address;
            bus_out.burst_size = effective_burst_size;
            bus_out.read_n_write = to_memory;
            bus_out.begin_transaction = 1'b1;
        end
        if (state == dma_pkg::state_write_burst) begin
            bus_out.address_data = write_word;
            bus_out.data_valid = 1'b1;
        end
        bus_out.end_transaction = state == dma_pkg::state_bus_error ||
                                  (state == dma_pkg::state_end_burst && !to_memory);
    end

    assign request = state == dma_pkg::state_request_bus;
    assign done = state == dma_pkg::state_end_burst && last_burst;
    assign abort = state == dma_pkg::state_bus_error;

endmodule

// File: hdl/dma_local_sram.sv
// DMA local word memory
module dma_local_sram #(
    parameter int MEMORY_ADDRESS_WIDTH = 9
) (
    input  logic                            clock,
    input  logic [MEMORY_ADDRESS_WIDTH-1:0] address,
    input  logic                            write_enable,
    input  logic [31:0]                     write_data,
    output logic [31:0]                     read_data
);

    logic [31:0] memory [2**MEMORY_ADDRESS_WIDTH];

    // Read returns the old word on a write to the same index
    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[address] <= write_data;
        end
        read_data <= memory[address];
    end

endmodule

// File: hdl/dma_pkg.sv
// DMA shared definitions
package dma_pkg;

    localparam int BLOCK_SIZE_WIDTH = 10;
    localparam int BURST_SIZE_WIDTH = 8;

    // Default local memory index width, used by the struct fields
    localparam int MEMORY_ADDRESS_WIDTH = 9;

    // Processor register selector
    typedef enum logic [2:0] {
        select_none                 = 3'd0,
        select_bus_start_address    = 3'd1,
        select_memory_start_address = 3'd2,
        select_block_size           = 3'd3,
        select_burst_size           = 3'd4,
        select_status_control       = 3'd5
    } dma_reg_select_e;

    typedef enum logic [2:0] {
        state_idle,
        state_request_bus,
        state_init_burst,
        state_read_burst,
        state_write_burst,
        state_end_burst,
        state_bus_error
    } dma_transfer_state_e;

    // Control field
    typedef enum logic [1:0] {
        direction_off           = 2'd0,
        direction_bus_to_memory = 2'd1,
        direction_memory_to_bus = 2'd2
    } dma_direction_e;

    typedef struct packed {
        dma_reg_select_e select;
        logic            write;
        logic [31:0]     data;
    } cpu_access_t;

    // Register values seen by the engine
    typedef struct packed {
        logic [31:0]                   bus_start_address;
        logic [MEMORY_ADDRESS_WIDTH-1:0] memory_start_address;
        logic [BLOCK_SIZE_WIDTH-1:0]   block_size;
        logic [BURST_SIZE_WIDTH-1:0]   burst_size;
        logic [BLOCK_SIZE_WIDTH-1:0]   transfer_count;
        dma_direction_e                direction;
    } dma_config_t;

    typedef struct packed {
        logic [31:0]                 address_data;
        logic [BURST_SIZE_WIDTH-1:0] burst_size;
        logic                        read_n_write;
        logic                        begin_transaction;
        logic                        end_transaction;
        logic                        data_valid;
    } bus_master_t;

    typedef struct packed {
        logic        grant;
        logic [31:0] address_data;
        logic        data_valid;
        logic        busy;
        logic        end_transaction;
        logic        error;
    } bus_target_t;

endpackage

// File: hdl/dma_registers.sv
// DMA processor registers
module dma_registers #(
    parameter int MEMORY_ADDRESS_WIDTH = 9
) (
    input  logic                 clock,
    input  logic                 reset,
    input  dma_pkg::cpu_access_t cpu,
    input  logic                 done,
    input  logic                 abort,
    output dma_pkg::dma_config_t config_out,
    output logic                 start,
    output logic [31:0]          result
);

    logic [31:0]                           bus_start_address;
    logic [MEMORY_ADDRESS_WIDTH-1:0]       memory_start_address;
    logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0]  block_size;
    logic [dma_pkg::BURST_SIZE_WIDTH-1:0]  burst_size;
    logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0]  transfer_count;
    dma_pkg::dma_direction_e               direction;
    logic                                  busy;
    logic                                  error;
    logic                                  start_request;

    // Bursts needed for a block, rounded up
    function automatic logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0] count_bursts(
        input logic [dma_pkg::BLOCK_SIZE_WIDTH-1:0] words,
        input logic [dma_pkg::BURST_SIZE_WIDTH-1:0] burst
    );
        logic [dma_pkg::BLOCK_SIZE_WIDTH:0] span;
        logic [dma_pkg::BURST_SIZE_WIDTH:0] divisor;
        logic [dma_pkg::BLOCK_SIZE_WIDTH:0] quotient;
        span = words + burst;
        divisor = {1'b0, burst} + 1'b1;
        quotient = span / divisor;
        return quotient[dma_pkg::BLOCK_SIZE_WIDTH-1:0];
    endfunction

    // Only a real direction with a nonempty block starts the engine
    assign start_request = (cpu.data[1:0] == dma_pkg::direction_bus_to_memory ||
                            cpu.data[1:0] == dma_pkg::direction_memory_to_bus) &&
                           block_size != '0 && !busy;

    always_ff @(posedge clock) begin
        if (reset) begin
            bus_start_address <= '0;
            memory_start_address <= '0;
            block_size <= '0;
            burst_size <= '0;
            transfer_count <= '0;
            direction <= dma_pkg::direction_off;
            busy <= 1'b0;
            error <= 1'b0;
            start <= 1'b0;
            result <= '0;
        end else begin
            start <= 1'b0;
            if (cpu.write) begin
                case (cpu.select)
                    dma_pkg::select_bus_start_address: bus_start_address <= cpu.data;
                    dma_pkg::select_memory_start_address: begin
                        memory_start_address <= cpu.data[MEMORY_ADDRESS_WIDTH-1:0];
                    end
                    dma_pkg::select_block_size: begin
                        block_size <= cpu.data[dma_pkg::BLOCK_SIZE_WIDTH-1:0];
                        transfer_count <= count_bursts(
                            cpu.data[dma_pkg::BLOCK_SIZE_WIDTH-1:0], burst_size);
                    end
                    dma_pkg::select_burst_size: begin
                        burst_size <= cpu.data[dma_pkg::BURST_SIZE_WIDTH-1:0];
                        transfer_count <= count_bursts(
                            block_size, cpu.data[dma_pkg::BURST_SIZE_WIDTH-1:0]);
                    end
                    dma_pkg::select_status_control: begin
                        if (start_request) begin
                            direction <= dma_pkg::dma_direction_e'(cpu.data[1:0]);
                            start <= 1'b1;
                            busy <= 1'b1;
                            error <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end else begin
                case (cpu.select)
                    dma_pkg::select_bus_start_address: result <= bus_start_address;
                    dma_pkg::select_memory_start_address: result <= 32'(memory_start_address);
                    dma_pkg::select_block_size: result <= 32'(block_size);
                    dma_pkg::select_burst_size: result <= 32'(burst_size);
                    dma_pkg::select_status_control: result <= {30'b0, error, busy};
                    default: ;
                endcase
            end
            // Engine finished or gave up
            if (done || abort) begin
                busy <= 1'b0;
                direction <= dma_pkg::direction_off;
            end
            if (abort) begin
                error <= 1'b1;
            end
        end
    end

    assign config_out.bus_start_address = bus_start_address;
    assign config_out.memory_start_address =
        dma_pkg::MEMORY_ADDRESS_WIDTH'(memory_start_address);
    assign config_out.block_size = block_size;
    assign config_out.burst_size = burst_size;
    assign config_out.transfer_count = transfer_count;
    assign config_out.direction = direction;

endmodule

// File: hdl/dma_subsystem.sv
// DMA subsystem top level
module dma_subsystem #(
    parameter int MEMORY_ADDRESS_WIDTH = 9
) (
    input  logic                 clock,
    input  logic                 reset,
    input  dma_pkg::cpu_access_t cpu,
    output logic [31:0]          result,
    output logic                 request,
    input  dma_pkg::bus_target_t bus_in,
    output dma_pkg::bus_master_t bus_out
);

    dma_pkg::dma_config_t            transfer_config;
    logic                            start;
    logic                            done;
    logic                            abort;
    logic [MEMORY_ADDRESS_WIDTH-1:0] sram_address;
    logic                            sram_write_enable;
    logic [31:0]                     sram_write_data;
    logic [31:0]                     sram_read_data;

    dma_registers #(
        .MEMORY_ADDRESS_WIDTH(MEMORY_ADDRESS_WIDTH)
    ) i_registers (
        .clock     (clock),
        .reset     (reset),
        .cpu       (cpu),
        .done      (done),
        .abort     (abort),
        .config_out(transfer_config),
        .start     (start),
        .result    (result)
    );

    dma_burst_engine #(
        .MEMORY_ADDRESS_WIDTH(MEMORY_ADDRESS_WIDTH)
    ) i_burst_engine (
        .clock            (clock),
        .reset            (reset),
        .config_in        (transfer_config),
        .start            (start),
        .done             (done),
        .abort            (abort),
        .request          (request),
        .bus_in           (bus_in),
        .bus_out          (bus_out),
        .sram_address     (sram_address),
        .sram_write_enable(sram_write_enable),
        .sram_write_data  (sram_write_data),
        .sram_read_data   (sram_read_data)
    );

    dma_local_sram #(
        .MEMORY_ADDRESS_WIDTH(MEMORY_ADDRESS_WIDTH)
    ) i_local_sram (
        .clock       (clock),
        .address     (sram_address),
        .write_enable(sram_write_enable),
        .write_data  (sram_write_data),
        .read_data   (sram_read_data)
    );

endmodule

// File: verification/dma_bus_target.sv
// DMA bus target model
module dma_bus_target (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 request,
    input  dma_pkg::bus_master_t bus_out,
    output dma_pkg::bus_target_t bus_in,
    input  logic                 error_enable,
    input  logic [31:0]          error_address
);

    logic [31:0] memory [1024];
    logic        active;
    logic        reading;
    logic        hold;
    logic [9:0]  word_index;
    logic [8:0]  words_left;
    int          grant_delay;

    // Target responds on the falling edge, the DUT samples on the rising one
    always @(negedge clock) begin
        if (reset) begin
            bus_in <= '0;
            active = 1'b0;
            reading = 1'b0;
            grant_delay = $urandom_range(5, 0);
        end else begin
            bus_in.error <= 1'b0;
            bus_in.end_transaction <= 1'b0;
            bus_in.data_valid <= 1'b0;
            // Grant after a random delay while request is held
            if (request) begin
                if (grant_delay == 0) begin
                    bus_in.grant <= 1'b1;
                end else begin
                    grant_delay--;
                end
            end else begin
                bus_in.grant <= 1'b0;
                grant_delay = $urandom_range(5, 0);
            end
            if (bus_out.begin_transaction) begin
                word_index = bus_out.address_data[11:2];
                words_left = 9'(bus_out.burst_size) + 9'd1;
                reading = bus_out.read_n_write;
                active = 1'b1;
                bus_in.busy <= 1'b0;
                if (error_enable && bus_out.address_data == error_address) begin
                    bus_in.error <= 1'b1;
                    active = 1'b0;
                end
            end else if (active && reading) begin
                // Read burst with random gaps, end follows the last word
                if (words_left == 0) begin
                    bus_in.end_transaction <= 1'b1;
                    active = 1'b0;
                end else if ($urandom_range(3, 0) != 0) begin
                    bus_in.data_valid <= 1'b1;
                    bus_in.address_data <= memory[word_index];
                    word_index++;
                    words_left--;
                end
            end else if (active) begin
                // Write burst, a word is taken on each cycle without busy
                hold = words_left != 0 && $urandom_range(2, 0) == 0;
                bus_in.busy <= hold;
                if (bus_out.data_valid && !hold && words_left != 0) begin
                    memory[word_index] = bus_out.address_data;
                    word_index++;
                    words_left--;
                end
                if (bus_out.end_transaction) begin
                    active = 1'b0;
                    bus_in.busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: verification/dma_tb.sv
// DMA subsystem testbench
module dma_tb;

    logic                 clock;
    logic                 reset;
    dma_pkg::cpu_access_t cpu;
    logic [31:0]          result;
    logic                 request;
    dma_pkg::bus_target_t bus_in;
    dma_pkg::bus_master_t bus_out;
    logic                 error_enable;
    logic [31:0]          error_address;

    int          error_count;
    int          timeout_count;
    int          begins_seen;
    int          end_pulses;
    int          words_moved;
    int          size_expected;
    logic [31:0] expected_base;
    int          expected_block;
    int          expected_burst;
    logic        expected_read;
    logic [31:0] expected_memory [1024];

    dma_subsystem #(
        .MEMORY_ADDRESS_WIDTH(9)
    ) i_dut (
        .clock  (clock),
        .reset  (reset),
        .cpu    (cpu),
        .result (result),
        .request(request),
        .bus_in (bus_in),
        .bus_out(bus_out)
    );

    dma_bus_target i_target (
        .clock        (clock),
        .reset        (reset),
        .request      (request),
        .bus_out      (bus_out),
        .bus_in       (bus_in),
        .error_enable (error_enable),
        .error_address(error_address)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic note_failure(input string message);
        error_count++;
        $display("Failure at %0t: %s", $time, message);
    endtask

    // Bursts of at most burst + 1 words until the block is used up
    function automatic int bursts_for_block(input int block, input int burst);
        int words;
        int bursts;
        words = block;
        bursts = 0;
        while (words > 0) begin
            words -= burst + 1;
            bursts++;
        end
        return bursts;
    endfunction

    // Request holds until the target grants the bus
    assert property (@(posedge clock) disable iff (reset)
        request && !bus_in.grant |=> request)
    else note_failure("request dropped before the bus was granted");

    assert property (@(posedge clock) disable iff (reset)
        bus_out.begin_transaction |-> $past(bus_in.grant))
    else note_failure("a burst began without a grant");

    // Each burst header against the block split
    always @(negedge clock) begin
        if (!reset && bus_out.begin_transaction) begin
            words_moved = begins_seen * (expected_burst + 1);
            size_expected = expected_block - words_moved - 1;
            if (size_expected > expected_burst) begin
                size_expected = expected_burst;
            end
            assert (bus_out.burst_size == 8'(size_expected))
            else report_mismatch("burst_size", size_expected, bus_out.burst_size);
            assert (bus_out.address_data == expected_base + 4 * words_moved)
            else report_mismatch("address_data", expected_base + 4 * words_moved,
                                 bus_out.address_data);
            assert (bus_out.read_n_write == expected_read)
            else report_mismatch("read_n_write", expected_read, bus_out.read_n_write);
            begins_seen++;
        end
        if (!reset && bus_out.end_transaction) begin
            end_pulses++;
        end
    end

    task automatic write_register(input dma_pkg::dma_reg_select_e select,
                                  input logic [31:0] value);
        @(negedge clock);
        cpu.select = select;
        cpu.write = 1'b1;
        cpu.data = value;
        @(negedge clock);
        cpu.select = dma_pkg::select_none;
        cpu.write = 1'b0;
    endtask

    task automatic read_register(input dma_pkg::dma_reg_select_e select,
                                 output logic [31:0] value);
        @(negedge clock);
        cpu.select = select;
        cpu.write = 1'b0;
        @(negedge clock);
        cpu.select = dma_pkg::select_none;
        value = result;
    endtask

    task automatic check_register(input dma_pkg::dma_reg_select_e select,
                                  input logic [31:0] expected, input string name);
        logic [31:0] value;
        read_register(select, value);
        assert (value == expected) else report_mismatch(name, expected, value);
    endtask

    task automatic run_transfer(input dma_pkg::dma_direction_e direction,
                                input logic [31:0] bus_address, input int memory_index,
                                input int block, input int burst,
                                input logic [31:0] final_status);
        logic [31:0] status;
        int          polls;
        int          bursts;
        int          ends_expected;
        write_register(dma_pkg::select_bus_start_address, bus_address);
        write_register(dma_pkg::select_memory_start_address, memory_index);
        write_register(dma_pkg::select_block_size, block);
        write_register(dma_pkg::select_burst_size, burst);
        expected_base = bus_address;
        expected_block = block;
        expected_burst = burst;
        expected_read = direction == dma_pkg::direction_bus_to_memory;
        begins_seen = 0;
        end_pulses = 0;
        write_register(dma_pkg::select_status_control, 32'(direction));
        check_register(dma_pkg::select_status_control, 32'd1, "status");
        polls = 0;
        status = 32'd1;
        while (status[0] && polls < 500) begin
            read_register(dma_pkg::select_status_control, status);
            polls++;
        end
        if (status[0]) begin
            timeout_count++;
            $display("Timeout at %0t: transfer still busy after %0d status reads",
                     $time, polls);
        end
        assert (status == final_status) else report_mismatch("status", final_status, status);
        // Control field is cleared once the engine stops
        assert (i_dut.transfer_config.direction == dma_pkg::direction_off)
        else report_mismatch("direction", 32'(dma_pkg::direction_off),
                             32'(i_dut.transfer_config.direction));
        if (final_status == 32'd0) begin
            bursts = bursts_for_block(block, burst);
            assert (begins_seen == bursts)
            else report_mismatch("burst count", bursts, begins_seen);
            // Only write bursts are closed by the DUT
            ends_expected = expected_read ? 0 : bursts;
            assert (end_pulses == ends_expected)
            else report_mismatch("end_transaction pulses", ends_expected, end_pulses);
        end
    endtask

    initial begin
        logic [31:0] value;
        int          index;
        void'($urandom(29873));
        error_count = 0;
        timeout_count = 0;
        begins_seen = 0;
        end_pulses = 0;
        expected_base = '0;
        expected_block = 0;
        expected_burst = 0;
        expected_read = 1'b0;
        cpu = '0;
        error_enable = 1'b0;
        error_address = '0;
        reset = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // Everything reads zero out of reset
        check_register(dma_pkg::select_bus_start_address, 32'd0, "bus_start_address");
        check_register(dma_pkg::select_memory_start_address, 32'd0, "memory_start_address");
        check_register(dma_pkg::select_block_size, 32'd0, "block_size");
        check_register(dma_pkg::select_burst_size, 32'd0, "burst_size");
        check_register(dma_pkg::select_status_control, 32'd0, "status");

        // Readback truncated to field width
        for (index = 0; index < 4; index++) begin
            value = $urandom;
            write_register(dma_pkg::select_bus_start_address, value);
            check_register(dma_pkg::select_bus_start_address, value, "bus_start_address");
            write_register(dma_pkg::select_memory_start_address, value);
            check_register(dma_pkg::select_memory_start_address, value & 32'h1ff,
                           "memory_start_address");
            write_register(dma_pkg::select_block_size, value);
            check_register(dma_pkg::select_block_size, value & 32'h3ff, "block_size");
            write_register(dma_pkg::select_burst_size, value);
            check_register(dma_pkg::select_burst_size, value & 32'hff, "burst_size");
            // Control value 3 names no direction and starts nothing
            write_register(dma_pkg::select_status_control, value | 32'd3);
            check_register(dma_pkg::select_status_control, 32'd0, "status");
        end

        // Random region A at word 64 inside a fill pattern
        for (index = 0; index < 1024; index++) begin
            value = {16'(index) ^ 16'hbeef, 16'(index)};
            if (index >= 64 && index < 109) begin
                value = $urandom;
            end
            i_target.memory[index] = value;
            expected_memory[index] = value;
        end
        run_transfer(dma_pkg::direction_bus_to_memory, 32'h100, 37, 45, 7, 32'd0);
        run_transfer(dma_pkg::direction_memory_to_bus, 32'h800, 37, 45, 5, 32'd0);
        for (index = 0; index < 45; index++) begin
            expected_memory[512 + index] = expected_memory[64 + index];
        end
        for (index = 0; index < 1024; index++) begin
            assert (i_target.memory[index] == expected_memory[index])
            else report_mismatch($sformatf("memory[%0d]", index), expected_memory[index],
                                 i_target.memory[index]);
        end

        // Error on the second burst followed by a clean transfer
        error_enable = 1'b1;
        error_address = 32'h210;
        run_transfer(dma_pkg::direction_bus_to_memory, 32'h200, 100, 20, 3, 32'd2);
        assert (end_pulses == 1) else report_mismatch("end_transaction pulses", 1, end_pulses);
        error_enable = 1'b0;
        run_transfer(dma_pkg::direction_bus_to_memory, 32'h200, 100, 20, 3, 32'd0);

        $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
